// File: compile.f
lsu_pkg.sv
lsu_req_align.sv
lsu_txn_ctrl.sv
lsu_rdata_align.sv
lsu_obi_master.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

// File: tb_lsu.sv
`timescale 1ns/1ps
/* Testbench top with clock, reset, directed and random stimulus,
   OBI memory model with random grant and response delays */
module tb_lsu;

  localparam logic [31:0] SEED       = 32'h4c59_18f2;
  localparam int          N_DIRECTED = 50;
  localparam int          N_RANDOM   = 200;
  localparam int          ERR_BIT    = 10;  // Address bit of the error region

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       valid_0_i, sext_i, we_i;
  logic [31:0]                op_a_i, op_b_i, wdata_i;
  lsu_pkg::lsu_size_e         size_i;
  logic                       ready_0_o, split_0_o, valid_1_o, err_1_o;
  logic [31:0]                rdata_1_o;
  logic                       data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i;
  logic [31:0]                data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]                 data_be_o;
  logic                       busy_o, interruptible_o, check_idle, timeout;
  int                         val_errs, flag_errs, proto_errs;

  logic [31:0] mem [256];
  logic [31:0] resp_data_q [$];  // Responses waiting, in grant order
  logic        resp_err_q [$];
  int          resp_due_q [$];
  int          cycle, last_due, due;
  int          gnt_wait = 0;

  always #10 clk = ~clk;  // 20 ns period

  lsu_top DUT (.*);

  lsu_checker #(.NUM_INSTR(N_DIRECTED + N_RANDOM)) u_checker (
    .check_idle_i (check_idle), .val_errs_o (val_errs), .flag_errs_o (flag_errs),
    .proto_errs_o (proto_errs), .timeout_o (timeout), .*);

  ////////////////////
  // Memory model
  ////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle    = 0;
      last_due = 0;
    end else begin
      cycle++;
      if (data_req_o && data_gnt_i) begin
        for (int i = 0; i < 4; i++)
          if (data_we_o && data_be_o[i]) mem[data_addr_o[9:2]][8*i +: 8] = data_wdata_o[8*i +: 8];
        resp_data_q.push_back(mem[data_addr_o[9:2]]);
        resp_err_q.push_back(data_addr_o[ERR_BIT]);
        due = cycle + $urandom_range(3, 1);
        if (due <= last_due) due = last_due + 1;  // Keep order
        last_due = due;
        resp_due_q.push_back(due);
        gnt_wait = $urandom_range(3);  // Delay for the next request
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
    end
  end

  always @(negedge clk) begin
    data_gnt_i    = rst_n && (gnt_wait == 0);
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    if (rst_n && resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_data_q.pop_front();
      data_err_i    = resp_err_q.pop_front();
      void'(resp_due_q.pop_front());
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic [31:0] wd,
                       input lsu_pkg::lsu_size_e sz, input logic sx, input logic w);
    valid_0_i = 1'b1;
    op_a_i    = a;
    op_b_i    = b;
    wdata_i   = wd;
    size_i    = sz;
    sext_i    = sx;
    we_i      = w;
    do @(posedge clk); while (!ready_0_o);
    @(negedge clk);
    valid_0_i = 1'b0;
  endtask

  task automatic pulse_idle_check;
    check_idle = 1'b1;
    @(negedge clk);
    check_idle = 1'b0;
  endtask

  always @(posedge clk) begin
    if (timeout) begin
      $display("Run stopped at the cycle limit, DUT stopped responding");
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    rst_n         = 1'b0;
    valid_0_i     = 1'b0;
    op_a_i        = '0;
    op_b_i        = '0;
    wdata_i       = '0;
    size_i        = lsu_pkg::SIZE_BYTE;
    sext_i        = 1'b0;
    we_i          = 1'b0;
    check_idle    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    data_err_i    = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) mem[i] = i * 32'h0101_0101 ^ 32'hA5C3_5A3C;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    pulse_idle_check();
    // Loads of every size, sign flag and offset, misaligned ones split
    for (int s = 0; s < 3; s++)
      for (int x = 0; x < 2; x++)
        for (int o = 0; o < 4; o++)
          issue(32'h100 + 16 * s, o, '0, lsu_pkg::lsu_size_e'(s), x, 1'b0);
    // Store at each size and offset, then read back a word over the same bytes
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 4; o++) begin
        issue(32'h200 + 16 * s, o, $urandom, lsu_pkg::lsu_size_e'(s), 1'b0, 1'b1);
        issue(32'h200 + 16 * s, o, '0, lsu_pkg::SIZE_WORD, 1'b0, 1'b0);
      end
    issue(32'h3F0, 32'hE, '0, lsu_pkg::SIZE_WORD, 1'b0, 1'b0);  // Second half faults
    issue(32'h7F0, 32'hF, '0, lsu_pkg::SIZE_HALF, 1'b1, 1'b0);  // First half faults
    // Random traffic, mostly back to back
    for (int n = 0; n < N_RANDOM; n++) begin
      issue($urandom_range(32'h3FF) | (($urandom_range(7) == 0) ? 32'h400 : 32'h0),
            $urandom_range(15), $urandom, lsu_pkg::lsu_size_e'($urandom_range(2)),
            $urandom_range(1), $urandom_range(1));
      repeat ($urandom_range(3) == 0) @(negedge clk);
    end
    while (busy_o) @(negedge clk);  // Drain
    repeat (2) @(negedge clk);
    pulse_idle_check();
    @(negedge clk);
    $display("Errors: value %0d, error flag %0d, protocol %0d", val_errs, flag_errs, proto_errs);
    if (val_errs + flag_errs + proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: lsu_checker.sv
`timescale 1ns/1ps
/* Result checker with reference load model, shadow memory, expected-result queue,
   bus request checks, outstanding count and error counters */
module lsu_checker #(
  parameter int NUM_INSTR = 1  // Sets the cycle limit
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       check_idle_i,  // Unit should be idle now
  input  logic                       valid_0_i,
  input  logic [lsu_pkg::ADDR_W-1:0] op_a_i,
  input  logic [lsu_pkg::ADDR_W-1:0] op_b_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       sext_i,
  input  logic                       we_i,
  input  logic                       ready_0_o,
  input  logic                       split_0_o,
  input  logic                       valid_1_o,
  input  logic [lsu_pkg::DATA_W-1:0] rdata_1_o,
  input  logic                       err_1_o,
  input  logic                       data_req_o,
  input  logic [lsu_pkg::ADDR_W-1:0] data_addr_o,
  input  logic                       data_we_o,
  input  logic [lsu_pkg::BE_W-1:0]   data_be_o,
  input  logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       busy_o,
  input  logic                       interruptible_o,
  output int                         val_errs_o,    // Wrong result data
  output int                         flag_errs_o,   // Wrong error flag
  output int                         proto_errs_o,  // Bus and handshake problems
  output logic                       timeout_o
);

  logic [31:0] shadow [256];  // Expected memory contents
  logic [33:0] exp_q [$];     // {we, err, data} in issue order
  int          grants_in_instr;
  int          outstanding;   // Grants minus responses
  int          cycles;

  initial begin
    for (int i = 0; i < 256; i++) shadow[i] = i * 32'h0101_0101 ^ 32'hA5C3_5A3C;
  end

  function automatic int num_bytes(input lsu_pkg::lsu_size_e size);
    return (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
  endfunction

  // Access spills into the next word
  function automatic logic crosses(input logic [31:0] addr, input lsu_pkg::lsu_size_e size);
    return (int'(addr[1:0]) + num_bytes(size)) > 4;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Byte-wise read from the shadow, then extension by size
  function automatic logic [31:0] load_ref(input logic [31:0] addr,
                                           input lsu_pkg::lsu_size_e size, input logic sext);
    logic [31:0] val;
    logic [31:0] a;
    val = '0;
    for (int i = 0; i < num_bytes(size); i++) begin
      a = addr + i;
      val[8*i +: 8] = shadow[a[9:2]][8*a[1:0] +: 8];
    end
    if (sext && size == lsu_pkg::SIZE_BYTE) val[31:8] = {24{val[7]}};
    if (sext && size == lsu_pkg::SIZE_HALF) val[31:16] = {16{val[15]}};
    return val;
  endfunction

  function automatic logic err_ref(input logic [31:0] addr, input lsu_pkg::lsu_size_e size);
    logic [31:0] a;
    err_ref = 1'b0;
    for (int i = 0; i < num_bytes(size); i++) begin
      a = addr + i;
      err_ref = err_ref | a[10];  // Error region
    end
  endfunction

  // {be, wdata} of the bytes that land in the word of this address phase
  function automatic logic [35:0] bus_lanes(input logic [31:0] addr,
                                            input lsu_pkg::lsu_size_e size,
                                            input logic [31:0] wd, input logic upper);
    logic [31:0] a;
    logic [29:0] word;
    logic [3:0]  be;
    logic [31:0] data;
    be   = '0;
    data = '0;
    word = addr[31:2] + (upper ? 30'd1 : 30'd0);
    for (int i = 0; i < num_bytes(size); i++) begin
      a = addr + i;
      if (a[31:2] == word) begin
        be[a[1:0]]          = 1'b1;
        data[8*a[1:0] +: 8] = wd[8*i +: 8];  // Byte i of the operand
      end
    end
    return {be, data};
  endfunction

  task automatic store_ref(input logic [31:0] addr, input lsu_pkg::lsu_size_e size,
                           input logic [31:0] wd);
    logic [31:0] a;
    for (int i = 0; i < num_bytes(size); i++) begin
      a = addr + i;
      shadow[a[9:2]][8*a[1:0] +: 8] = wd[8*i +: 8];
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  assign timeout_o = cycles > 40 * NUM_INSTR + 200;

  always @(posedge clk) begin : compare
    logic [31:0] sum;
    logic [33:0] exp;
    logic [35:0] lanes;
    logic [31:0] mask;
    sum = op_a_i + op_b_i;
    if (!rst_n) begin
      grants_in_instr = 0;
      outstanding     = 0;
      cycles          = 0;
      val_errs_o      = 0;
      flag_errs_o     = 0;
      proto_errs_o    = 0;
    end else begin
      cycles++;
      if (data_req_o && data_gnt_i) begin
        lanes = bus_lanes(sum, size_i, wdata_i, grants_in_instr != 0);
        for (int l = 0; l < 4; l++) mask[8*l +: 8] = {8{lanes[32+l]}};
        if (data_be_o !== lanes[35:32]) begin
          $display("[FAIL] data_be_o exp %h got %h", lanes[35:32], data_be_o);
          proto_errs_o++;
        end
        if (data_we_o !== we_i) begin
          $display("[FAIL] data_we_o exp %h got %h", we_i, data_we_o);
          proto_errs_o++;
        end
        if (we_i && (data_wdata_o & mask) !== lanes[31:0]) begin  // Enabled lanes only
          $display("[FAIL] data_wdata_o exp %h got %h", lanes[31:0], data_wdata_o & mask);
          proto_errs_o++;
        end
        if (grants_in_instr == 0) begin
          if (data_addr_o !== sum) begin
            $display("[FAIL] data_addr_o exp %h got %h", sum, data_addr_o);
            proto_errs_o++;
          end
          if (split_0_o !== crosses(sum, size_i)) begin
            $display("[FAIL] split_0_o exp %h got %h", crosses(sum, size_i), split_0_o);
            proto_errs_o++;
          end
        end else if (data_addr_o !== {sum[31:2] + 30'd1, 2'b00}) begin  // Next word
          $display("[FAIL] data_addr_o exp %h got %h", {sum[31:2] + 30'd1, 2'b00}, data_addr_o);
          proto_errs_o++;
        end
        grants_in_instr++;
        outstanding++;
      end
      if (data_rvalid_i) outstanding--;
      if (outstanding > 2 || outstanding < 0) begin
        $display("Outstanding bus transactions out of range: %0d", outstanding);
        proto_errs_o++;
      end
      if (valid_0_i && ready_0_o) begin  // Instruction accepted
        if (grants_in_instr != (crosses(sum, size_i) ? 2 : 1)) begin
          $display("Instruction at %h accepted after %0d bus grants", sum, grants_in_instr);
          proto_errs_o++;
        end
        grants_in_instr = 0;
        if (we_i) begin
          store_ref(sum, size_i, wdata_i);
          exp_q.push_back({1'b1, err_ref(sum, size_i), 32'h0});
        end else begin
          exp_q.push_back({1'b0, err_ref(sum, size_i), load_ref(sum, size_i, sext_i)});
        end
      end
      if (valid_1_o) begin
        if (exp_q.size() == 0) begin
          $display("Result returned with no instruction outstanding");
          proto_errs_o++;
        end else begin
          exp = exp_q.pop_front();
          if (err_1_o !== exp[32]) begin
            $display("[FAIL] err_1_o exp %h got %h", exp[32], err_1_o);
            flag_errs_o++;
          end
          if (!exp[33] && rdata_1_o !== exp[31:0]) begin  // Loads only
            $display("[FAIL] rdata_1_o exp %h got %h", exp[31:0], rdata_1_o);
            val_errs_o++;
          end
        end
      end
      if (check_idle_i) begin
        if (busy_o !== 1'b0 || interruptible_o !== 1'b1 || data_req_o !== 1'b0 ||
            ready_0_o !== 1'b0 || valid_1_o !== 1'b0 || exp_q.size() != 0) begin
          $display("Unit not idle: busy %b interruptible %b, %0d results missing",
                   busy_o, interruptible_o, exp_q.size());
          proto_errs_o++;
        end
      end
    end
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
/* Load/store unit top, connects request alignment, transaction control,
   read data alignment and the OBI port */
module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Execute stage
  input  logic                       valid_0_i,
  input  logic [lsu_pkg::ADDR_W-1:0] op_a_i,
  input  logic [lsu_pkg::ADDR_W-1:0] op_b_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       sext_i,
  input  logic                       we_i,
  output logic                       ready_0_o,
  output logic                       split_0_o,

  // Writeback stage
  output logic                       valid_1_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_1_o,
  output logic                       err_1_o,

  // OBI data bus
  output logic                       data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0] data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  input  logic                       data_err_i,

  // Status
  output logic                       busy_o,
  output logic                       interruptible_o
);

  ////////////////////
  // Internal nets
  ////////////////////

  logic [lsu_pkg::ADDR_W-1:0] req_addr;   // Aligned request fields
  logic [lsu_pkg::BE_W-1:0]   req_be;
  logic [lsu_pkg::DATA_W-1:0] req_wdata;
  lsu_pkg::lsu_wb_ctrl_t      wb_ctrl;

  logic                       trans_valid;
  logic                       gnt;        // Qualified grant
  logic                       rvalid;
  logic [lsu_pkg::DATA_W-1:0] rdata;
  logic                       err;
  logic                       queue_busy;

  lsu_req_align u_req_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_0_i (valid_0_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .wdata_i   (wdata_i),
    .size_i    (size_i),
    .sext_i    (sext_i),
    .we_i      (we_i),
    .grant_i   (gnt),
    .addr_o    (req_addr),
    .be_o      (req_be),
    .wdata_o   (req_wdata),
    .split_0_o (split_0_o),
    .wb_ctrl_o (wb_ctrl)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .split_0_i       (split_0_o),
    .gnt_i           (gnt),
    .rvalid_i        (rvalid),
    .queue_busy_i    (queue_busy),
    .trans_valid_o   (trans_valid),
    .ready_0_o       (ready_0_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  // Control word enters the queue on the same grant the counter sees
  lsu_rdata_align u_rdata_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_i    (gnt),
    .wb_ctrl_i (wb_ctrl),
    .rvalid_i  (rvalid),
    .rdata_i   (rdata),
    .err_i     (err),
    .valid_1_o (valid_1_o),
    .rdata_1_o (rdata_1_o),
    .err_1_o   (err_1_o),
    .busy_o    (queue_busy)
  );

  lsu_obi_master u_obi_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .addr_i        (req_addr),
    .we_i          (we_i),
    .be_i          (req_be),
    .wdata_i       (req_wdata),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i),
    .gnt_o         (gnt),
    .rvalid_o      (rvalid),
    .rdata_o       (rdata),
    .err_o         (err)
  );

endmodule

// File: lsu_obi_master.sv
`timescale 1ns/1ps
/* OBI data port, holds an address phase until granted and forwards responses */
module lsu_obi_master (
  input  logic                       clk,
  input  logic                       rst_n,
  // Core side request
  input  logic                       trans_valid_i,
  input  logic [lsu_pkg::ADDR_W-1:0] addr_i,
  input  logic                       we_i,
  input  logic [lsu_pkg::BE_W-1:0]   be_i,
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,
  // OBI bus
  output logic                       data_req_o,
  output logic [lsu_pkg::ADDR_W-1:0] data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::BE_W-1:0]   data_be_o,
  output logic [lsu_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,
  input  logic                       data_err_i,
  // Core side response
  output logic                       gnt_o,     // Address phase done
  output logic                       rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       err_o
);

  logic req_pend_q;  // Request out on the bus but not yet granted

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_pend_q <= 1'b0;
    end else begin
      req_pend_q <= data_req_o && !data_gnt_i;
    end
  end

  // A started address phase stays up until the grant
  assign data_req_o   = trans_valid_i || req_pend_q;
  assign data_addr_o  = addr_i;
  assign data_we_o    = we_i;
  assign data_be_o    = be_i;
  assign data_wdata_o = wdata_i;

  assign gnt_o = data_req_o && data_gnt_i;

  // Responses come back in order, no filtering
  assign rvalid_o = data_rvalid_i;
  assign rdata_o  = data_rdata_i;
  assign err_o    = data_err_i;

endmodule

// File: lsu_rdata_align.sv
`timescale 1ns/1ps
/* Writeback control queue, read data reassembly and sign extension,
   bus error merge and result valid */
module lsu_rdata_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push_i,     // Transaction granted
  input  lsu_pkg::lsu_wb_ctrl_t      wb_ctrl_i,  // Its control word
  input  logic                       rvalid_i,   // Response, pops the head
  input  logic [lsu_pkg::DATA_W-1:0] rdata_i,
  input  logic                       err_i,
  output logic                       valid_1_o,  // One pulse per instruction
  output logic [lsu_pkg::DATA_W-1:0] rdata_1_o,
  output logic                       err_1_o,
  output logic                       busy_o
);

  lsu_pkg::lsu_wb_ctrl_t ctrl_q [lsu_pkg::MAX_OUTSTANDING];  // Grant order
  lsu_pkg::lsu_wb_ctrl_t head;

  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0]   wr_ptr_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0]   rd_ptr_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] fill_q;

  logic [lsu_pkg::DATA_W-1:0]   rdata_q;   // Low word of a split load
  logic                         err_q;     // Error seen on first half
  logic                         is_split;
  logic [2*lsu_pkg::DATA_W-1:0] rdata_full;
  logic [2*lsu_pkg::DATA_W-1:0] rdata_shift;

  ////////////////////
  // Control queue
  ////////////////////

  always_ff @(posedge clk) begin
    if (push_i) begin
      ctrl_q[wr_ptr_q] <= wb_ctrl_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i)   wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, rvalid_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  assign head   = ctrl_q[rd_ptr_q];  // Entry the current response belongs to
  assign busy_o = (fill_q != '0);

  ////////////////////
  // Split state
  ////////////////////

  always_ff @(posedge clk) begin
    if (rvalid_i && !head.we && !head.last) begin
      rdata_q <= rdata_i;  // Keep lower word for the second half
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (rvalid_i) begin
      err_q <= !head.last && err_i;  // Sticky across the split only
    end
  end

  ////////////////////
  // Result
  ////////////////////

  assign is_split = ((head.size == lsu_pkg::SIZE_WORD) && (head.offset != 2'b00)) ||
                    ((head.size == lsu_pkg::SIZE_HALF) && (head.offset == 2'b11));

  // Upper word duplicated so an in-word shift still wraps correctly
  assign rdata_full  = is_split ? {rdata_i, rdata_q} : {rdata_i, rdata_i};
  assign rdata_shift = rdata_full >> (8 * head.offset);

  always_comb begin
    case (head.size)
      lsu_pkg::SIZE_BYTE: rdata_1_o = {{24{head.sext && rdata_shift[7]}},  rdata_shift[7:0]};
      lsu_pkg::SIZE_HALF: rdata_1_o = {{16{head.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:            rdata_1_o = rdata_shift[31:0];
    endcase
  end

  assign valid_1_o = rvalid_i && head.last;
  assign err_1_o   = err_i || err_q;  // Either half faults the instruction

endmodule

// File: lsu_txn_ctrl.sv
`timescale 1ns/1ps
/* Outstanding-transaction counter, EX handshake,
   busy and interruptible status */
module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,        // EX stage holds a load/store
  input  logic split_0_i,        // First half of a split in address phase
  input  logic gnt_i,            // Qualified bus grant
  input  logic rvalid_i,         // Bus response
  input  logic queue_busy_i,     // Writeback control still queued
  output logic trans_valid_o,    // Request toward the bus
  output logic ready_0_o,        // Instruction leaves EX
  output logic busy_o,
  output logic interruptible_o
);

  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] cnt_q;     // Transactions in flight
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] cnt_next;
  logic                                          pend_q;    // Request seen without grant

  ////////////////////
  // Outstanding count
  ////////////////////

  // Room for one more address phase while below the limit
  assign trans_valid_o = valid_0_i && (cnt_q < lsu_pkg::MAX_OUTSTANDING);

  always_comb begin
    case ({gnt_i, rvalid_i})
      2'b10:   cnt_next = cnt_q + 1'b1;  // Grant only
      2'b01:   cnt_next = cnt_q - 1'b1;  // Response only
      default: cnt_next = cnt_q;         // Neither, or both in one cycle
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  // Hold EX through the first half of a split
  assign ready_0_o = gnt_i && valid_0_i && !split_0_i;

  ////////////////////
  // Status
  ////////////////////

  // An address phase that lasted a cycle may no longer be retracted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (gnt_i) begin
      pend_q <= 1'b0;
    end else if (trans_valid_o) begin
      pend_q <= 1'b1;
    end
  end

  // Only first cycle of a fresh request with nothing in flight is killable
  assign interruptible_o = !pend_q && (cnt_q == '0);

  assign busy_o = (cnt_q != '0) || trans_valid_o || pend_q || queue_busy_i;

endmodule

// File: lsu_req_align.sv
`timescale 1ns/1ps
/* Address adder, misaligned split detection and tracking,
   byte-enable generation and store-data lane rotation */
module lsu_req_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       valid_0_i,  // EX stage holds a load/store
  input  logic [lsu_pkg::ADDR_W-1:0] op_a_i,     // Base operand
  input  logic [lsu_pkg::ADDR_W-1:0] op_b_i,     // Offset operand
  input  logic [lsu_pkg::DATA_W-1:0] wdata_i,    // Store operand, lane 0 aligned
  input  lsu_pkg::lsu_size_e         size_i,
  input  logic                       sext_i,
  input  logic                       we_i,
  input  logic                       grant_i,    // Address phase accepted by the bus
  output logic [lsu_pkg::ADDR_W-1:0] addr_o,
  output logic [lsu_pkg::BE_W-1:0]   be_o,
  output logic [lsu_pkg::DATA_W-1:0] wdata_o,
  output logic                       split_0_o,  // First half of a two-phase access
  output lsu_pkg::lsu_wb_ctrl_t      wb_ctrl_o
);

  logic [lsu_pkg::ADDR_W-1:0]   addr_sum;   // Raw effective address
  logic [lsu_pkg::ADDR_W-1:0]   next_word;  // Aligned word after addr_sum
  logic [lsu_pkg::OFFSET_W-1:0] offset;
  logic                         split_q;    // Second address phase in progress

  assign addr_sum  = op_a_i + op_b_i;
  assign offset    = addr_sum[lsu_pkg::OFFSET_W-1:0];
  assign next_word = {addr_sum[lsu_pkg::ADDR_W-1:lsu_pkg::OFFSET_W] + 1'b1,
                      {lsu_pkg::OFFSET_W{1'b0}}};

  // Second phase always starts at byte 0 of the following word
  assign addr_o = split_q ? next_word : addr_sum;

  ////////////////////
  // Split detection
  ////////////////////

  always_comb begin
    split_0_o = 1'b0;
    if (valid_0_i && !split_q) begin
      case (size_i)
        lsu_pkg::SIZE_WORD: split_0_o = (offset != 2'b00);  // Any unaligned word
        lsu_pkg::SIZE_HALF: split_0_o = (offset == 2'b11);  // Crosses word boundary
        default:            split_0_o = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;       // Nothing in EX, next access starts in phase one
    end else if (grant_i) begin
      split_q <= split_0_o;  // Set after first half, cleared after second
    end
  end

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    case (size_i)
      lsu_pkg::SIZE_BYTE: be_o = 4'b0001 << offset;
      lsu_pkg::SIZE_HALF: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;  // Lower byte only, upper one follows
          endcase
        end else begin
          be_o = 4'b0001;  // Upper byte in lane 0 of next word
        end
      end
      default: begin
        if (!split_q) begin
          be_o = 4'b1111 << offset;  // Lanes from offset upward
        end else begin
          be_o = 4'b1111 >> (3'd4 - offset);  // Remaining low lanes
        end
      end
    endcase
  end

  // Rotate left so byte 0 of the operand sits in the lane of the address
  always_comb begin
    case (offset)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // Control word pushed on grant, offset kept from the original address
  assign wb_ctrl_o.size   = size_i;
  assign wb_ctrl_o.sext   = sext_i;
  assign wb_ctrl_o.we     = we_i;
  assign wb_ctrl_o.offset = offset;
  assign wb_ctrl_o.last   = !split_0_o;

endmodule

// File: lsu_pkg.sv
/* Shared widths, outstanding-transaction limit, access size encoding
   and the writeback control word of the load/store unit */
package lsu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ADDR_W   = 32;  // Byte address
  localparam int DATA_W   = 32;  // Bus and register data
  localparam int BE_W     = DATA_W / 8;  // One enable per byte lane
  localparam int OFFSET_W = 2;   // Byte offset inside a word

  // Bus transactions allowed in flight at once
  localparam int MAX_OUTSTANDING = 2;

  ////////////////////
  // Access size
  ////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2  // 2'd3 unused
  } lsu_size_e;

  ////////////////////
  // Writeback control
  ////////////////////

  // Captured per granted transaction, consumed when its response returns
  typedef struct packed {
    lsu_size_e           size;    // Access size of the instruction
    logic                sext;    // Sign-extend the loaded value
    logic                we;      // Store, response carries no data
    logic [OFFSET_W-1:0] offset;  // Byte offset of the original address
    logic                last;    // Low only for the first half of a split
  } lsu_wb_ctrl_t;  // 7 bits

endpackage
